// File: gbe_cpu_if.f
logic/gbe_cpu_pkg.sv
logic/gbe_arp_cache.sv
logic/gbe_packet_buffers.sv
logic/gbe_loopback_mover.sv
logic/gbe_cpu_regs.sv
logic/gbe_cpu_top.sv
testbench/gbe_cpu_assert.sv
testbench/gbe_cpu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = gbe_cpu_tb
FILELIST  = gbe_cpu_if.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fails if the log reports a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/gbe_cpu_tb.sv
`timescale 1ns/1ps
module gbe_cpu_tb import gbe_cpu_pkg::*; ();

  logic           cpu_clk;
  logic           cpu_rst;
  logic           wb_cyc;
  logic           wb_stb;
  logic           wb_we;
  logic [3:0]     wb_sel;
  logic [13:0]    wb_adr;
  logic [31:0]    wb_wdat;
  logic [31:0]    wb_rdat;
  logic           wb_ack;
  logic           wb_err;
  logic [31:0]    phy_status;
  logic [31:0]    phy_control;
  gbe_local_cfg_t local_cfg;

  // reference model state
  gbe_local_cfg_t cfg_m;
  logic [31:0]    phy_ctrl_m;
  logic [47:0]    arp_m [ARP_ENTRIES];
  logic [31:0]    tx_m [TXBUF_WORDS];
  logic [7:0]     arp_ents [8];
  logic [3:0]     cfg_idx [6];

  logic [31:0]    lcg_state;
  logic           hung;
  int             checks;
  int             errors;
  int             test_errors;
  string          test_name;

  gbe_cpu_top UUT (
    .cpu_clk(cpu_clk), .cpu_rst(cpu_rst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
    .wb_we_i(wb_we), .wb_sel_i(wb_sel), .wb_adr_i(wb_adr), .wb_dat_i(wb_wdat),
    .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack), .wb_err_o(wb_err), .phy_status_i(phy_status),
    .phy_control_o(phy_control), .local_cfg_o(local_cfg)
  );

  initial begin
    cpu_clk = 1'b0;
    forever #5 cpu_clk = ~cpu_clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 15);
  endfunction

  function automatic logic [31:0] apply_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  lanes);
    logic [31:0] mask;
    mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic logic [13:0] reg_addr(input logic [3:0] idx);
    return REG_BASE | {8'h0, idx, 2'b00};
  endfunction

  function automatic logic [13:0] mem_addr(input logic [13:0] base, input logic [8:0] word);
    return base | {3'b000, word, 2'b00};
  endfunction

  function automatic logic [31:0] expected_reg(input logic [3:0] idx);
    case (idx)
      REG_LOCAL_MAC_1:   return {16'h0, cfg_m.mac[47:32]};
      REG_LOCAL_MAC_0:   return cfg_m.mac[31:0];
      REG_LOCAL_GATEWAY: return {24'h0, cfg_m.gateway};
      REG_LOCAL_IPADDR:  return cfg_m.ip;
      REG_VALID_PORTS:   return {7'h0, cfg_m.promiscuous, 7'h0, cfg_m.enable, cfg_m.port};
      REG_PHY_CONTROL:   return phy_ctrl_m;
      default:           return 32'h0;
    endcase
  endfunction

  function automatic void model_reg_write(input logic [3:0] idx, input logic [31:0] data,
                                          input logic [3:0] lanes);
    logic [31:0] word;
    case (idx)
      REG_LOCAL_MAC_1: begin
        word = apply_lanes({16'h0, cfg_m.mac[47:32]}, data, lanes & 4'b0011);
        cfg_m.mac[47:32] = word[15:0];
      end
      REG_LOCAL_MAC_0: cfg_m.mac[31:0] = apply_lanes(cfg_m.mac[31:0], data, lanes);
      REG_LOCAL_GATEWAY: begin
        word = apply_lanes({24'h0, cfg_m.gateway}, data, lanes & 4'b0001);
        cfg_m.gateway = word[7:0];
      end
      REG_LOCAL_IPADDR: cfg_m.ip = apply_lanes(cfg_m.ip, data, lanes);
      REG_VALID_PORTS: begin
        word = apply_lanes(expected_reg(REG_VALID_PORTS), data, lanes);
        cfg_m.port        = word[15:0];
        cfg_m.enable      = word[16];
        cfg_m.promiscuous = word[24];
      end
      REG_PHY_CONTROL: phy_ctrl_m = apply_lanes(phy_ctrl_m, data, lanes);
      default: ;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (hung) return;
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s %s expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic bus_write(input logic [13:0] addr, input logic [31:0] data,
                           input logic [3:0] lanes);
    int n;
    if (hung) return;
    @(negedge cpu_clk);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = 1'b1;
    wb_sel  = lanes;
    wb_adr  = addr;
    wb_wdat = data;
    n = 0;
    do begin
      @(negedge cpu_clk);
      n++;
    end while (!wb_ack && n < 8);
    // address stays put so the merged write lands after ack
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    if (!wb_ack) begin
      hung = 1'b1;
      $display("bus write to address %h was never acknowledged", addr);
    end
  endtask

  task automatic bus_read(input logic [13:0] addr, output logic [31:0] data);
    int n;
    data = 32'h0;
    if (hung) return;
    @(negedge cpu_clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = addr;
    n = 0;
    do begin
      @(negedge cpu_clk);
      n++;
    end while (!wb_ack && n < 8);
    data   = wb_rdat;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    if (!wb_ack) begin
      hung = 1'b1;
      $display("bus read from address %h was never acknowledged", addr);
    end
  endtask

  // for_rx waits for a received size, otherwise for the transmit size to clear
  task automatic wait_sizes(input logic for_rx, output logic [31:0] sizes);
    logic met;
    int   n;
    met   = 1'b0;
    sizes = 32'h0;
    for (n = 0; n < 400 && !met && !hung; n++) begin
      bus_read(reg_addr(REG_BUFFER_SIZES), sizes);
      met = for_rx ? (sizes[11:0] != 12'd0) : (sizes[27:16] == 12'd0);
    end
    if (!met && !hung) begin
      hung = 1'b1;
      if (for_rx) $display("timeout waiting for a received packet size");
      else        $display("timeout waiting for the transmit size to clear");
    end
  endtask

  task automatic stage_packet(input int size);
    logic [31:0] first;
    logic [31:0] second;
    logic [3:0]  lanes;
    for (int i = 0; i < size; i++) begin
      first  = lcg_next();
      second = lcg_next();
      lanes  = 4'(lcg_next() >> 28);
      bus_write(mem_addr(TXBUF_BASE, 9'(i)), first, 4'hf);
      bus_write(mem_addr(TXBUF_BASE, 9'(i)), second, lanes);
      tx_m[9'(i)] = apply_lanes(first, second, lanes);
    end
    bus_write(reg_addr(REG_BUFFER_SIZES), {4'h0, 12'(size), 16'h0}, 4'b1100);
  endtask

  task automatic check_packet(input int size);
    logic [31:0] rd;
    for (int i = 0; i < size; i++) begin
      bus_read(mem_addr(RXBUF_BASE, 9'(i)), rd);
      check_value("rx word", 128'(tx_m[9'(i)]), 128'(rd));
    end
  endtask

  task automatic finish_test();
    $display("%s: %0d errors", test_name, errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] r;
    logic [31:0] data;
    logic [3:0]  lanes;
    logic [3:0]  idx;
    logic [7:0]  ent;
    logic        half;
    logic [31:0] a_word0;
    int          size_a;
    int          size_b;

    cpu_rst     = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_sel      = 4'h0;
    wb_adr      = 14'h0;
    wb_wdat     = 32'h0;
    phy_status  = 32'h0;
    lcg_state   = 32'd38;
    hung        = 1'b0;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    cfg_idx     = '{REG_LOCAL_MAC_1, REG_LOCAL_MAC_0, REG_LOCAL_GATEWAY, REG_LOCAL_IPADDR,
                    REG_VALID_PORTS, REG_PHY_CONTROL};
    cfg_m       = '{RST_MAC, RST_IP, RST_PORT, RST_GATEWAY, RST_ENABLE, RST_PROMISC};
    phy_ctrl_m  = RST_PHY_CONTROL;
    repeat (16) @(negedge cpu_clk);
    cpu_rst = 1'b0;

    test_name = "reset_values";
    for (int k = 0; k < 6; k++) begin
      bus_read(reg_addr(cfg_idx[3'(k)]), rd);
      check_value("register", 128'(expected_reg(cfg_idx[3'(k)])), 128'(rd));
    end
    bus_read(reg_addr(REG_BUFFER_SIZES), rd);
    check_value("buffer sizes", 128'(0), 128'(rd));
    check_value("local cfg", 128'(cfg_m), 128'(local_cfg));
    check_value("phy control", 128'(phy_ctrl_m), 128'(phy_control));
    finish_test();

    test_name = "config_writes";
    for (int k = 0; k < 40; k++) begin
      idx   = cfg_idx[3'(lcg_next() % 32'd6)];
      data  = lcg_next();
      lanes = 4'(lcg_next() >> 28);
      bus_write(reg_addr(idx), data, lanes);
      model_reg_write(idx, data, lanes);
      bus_read(reg_addr(idx), rd);
      check_value("readback", 128'(expected_reg(idx)), 128'(rd));
    end
    check_value("local cfg", 128'(cfg_m), 128'(local_cfg));
    check_value("phy control", 128'(phy_ctrl_m), 128'(phy_control));
    for (int k = 0; k < 3; k++) begin
      phy_status = lcg_next();
      bus_read(reg_addr(REG_PHY_STATUS), rd);
      check_value("phy status", 128'(phy_status), 128'(rd));
    end
    finish_test();

    test_name = "arp_cache";
    // fill whole entries first so partial writes merge with known data
    for (int k = 0; k < 8; k++) begin
      ent = 8'(lcg_next() >> 8);
      arp_ents[3'(k)] = ent;
      arp_m[ent] = {16'(lcg_next()), lcg_next()};
      bus_write(mem_addr(ARP_BASE, {ent, 1'b0}), {16'h0, arp_m[ent][47:32]}, 4'hf);
      bus_write(mem_addr(ARP_BASE, {ent, 1'b1}), arp_m[ent][31:0], 4'hf);
    end
    for (int k = 0; k < 24; k++) begin
      r     = lcg_next();
      ent   = arp_ents[3'(r % 32'd8)];
      half  = r[12];
      data  = lcg_next();
      lanes = 4'(lcg_next() >> 28);
      bus_write(mem_addr(ARP_BASE, {ent, half}), data, lanes);
      if (half) begin
        arp_m[ent][31:0] = apply_lanes(arp_m[ent][31:0], data, lanes);
      end else begin
        r = apply_lanes({16'h0, arp_m[ent][47:32]}, data, lanes);
        arp_m[ent][47:32] = r[15:0];
      end
    end
    for (int k = 0; k < 8; k++) begin
      ent = arp_ents[3'(k)];
      bus_read(mem_addr(ARP_BASE, {ent, 1'b0}), rd);
      check_value("entry high", 128'({16'h0, arp_m[ent][47:32]}), 128'(rd));
      bus_read(mem_addr(ARP_BASE, {ent, 1'b1}), rd);
      check_value("entry low", 128'(arp_m[ent][31:0]), 128'(rd));
    end
    finish_test();

    test_name = "loopback";
    size_a = int'(lcg_next() % 32'd24) + 1;
    stage_packet(size_a);
    bus_read(mem_addr(TXBUF_BASE, 9'd0), rd);
    check_value("tx word", 128'(tx_m[0]), 128'(rd));
    wait_sizes(1'b1, rd);
    check_value("rx size", 128'(size_a), 128'(rd[11:0]));
    check_value("tx size", 128'(0), 128'(rd[27:16]));
    check_packet(size_a);
    a_word0 = tx_m[0];
    finish_test();

    test_name = "back_pressure";
    size_b = int'(lcg_next() % 32'd24) + 1;
    if (size_b == size_a) size_b = size_a + 1;
    stage_packet(size_b);
    wait_sizes(1'b0, rd);
    check_value("held rx size", 128'(size_a), 128'(rd[11:0]));
    bus_read(mem_addr(RXBUF_BASE, 9'd0), rd);
    check_value("held rx word", 128'(a_word0), 128'(rd));
    // release the first packet
    bus_write(reg_addr(REG_BUFFER_SIZES), 32'h0, 4'b0001);
    wait_sizes(1'b1, rd);
    check_value("rx size", 128'(size_b), 128'(rd[11:0]));
    check_value("tx size", 128'(0), 128'(rd[27:16]));
    check_packet(size_b);
    check_value("bus error", 128'(0), 128'(wb_err));
    finish_test();

    $display("checks %0d, errors %0d, timeout %0d", checks, errors, hung);
    if (errors == 0 && !hung) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: testbench/gbe_cpu_assert.sv
`timescale 1ns/1ps
module gbe_cpu_assert import gbe_cpu_pkg::*; (
  input logic         cpu_clk,
  input logic         cpu_rst,
  input gbe_bus_req_t bus_req_i,
  input logic         ack_i,
  input logic         tx_ready_i,
  input logic         tx_done_i,
  input logic         rx_ready_i,
  input logic         rx_ack_i
);

  logic read_req;

  assign read_req = bus_req_i.cyc && bus_req_i.stb && !bus_req_i.we && !ack_i;

  ack_single: assert property (@(posedge cpu_clk) disable iff (cpu_rst) ack_i |=> !ack_i)
    else $error("bus ack high on two cycles in a row");

  read_ack: assert property (@(posedge cpu_clk) disable iff (cpu_rst) read_req |=> ack_i)
    else $error("read not acknowledged on the cycle after the request");

  // ready only drops in response to the mover's done pulse
  tx_ready_fall: assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    $fell(tx_ready_i) |-> $past(tx_done_i))
    else $error("tx_ready fell without tx_done");

  rx_ack_valid: assert property (@(posedge cpu_clk) disable iff (cpu_rst) rx_ack_i |-> rx_ready_i)
    else $error("rx_ack high while rx_ready is low");

endmodule

bind gbe_cpu_regs gbe_cpu_assert u_assert (
  .cpu_clk(cpu_clk), .cpu_rst(cpu_rst), .bus_req_i(bus_req_i), .ack_i(bus_ack_o),
  .tx_ready_i(tx_ready_o), .tx_done_i(tx_done_i), .rx_ready_i(rx_ready_i), .rx_ack_i(rx_ack_o)
);

// File: logic/gbe_cpu_top.sv
`timescale 1ns/1ps
module gbe_cpu_top import gbe_cpu_pkg::*; (
  input  logic           cpu_clk,
  input  logic           cpu_rst,
  input  logic           wb_cyc_i,
  input  logic           wb_stb_i,
  input  logic           wb_we_i,
  input  logic [3:0]     wb_sel_i,
  input  logic [13:0]    wb_adr_i,
  input  logic [31:0]    wb_dat_i,
  output logic [31:0]    wb_dat_o,
  output logic           wb_ack_o,
  output logic           wb_err_o,
  input  logic [31:0]    phy_status_i,
  output logic [31:0]    phy_control_o,
  output gbe_local_cfg_t local_cfg_o
);

  gbe_bus_req_t bus_req;
  logic [7:0]   arp_addr;
  logic [47:0]  arp_rdata;
  logic [47:0]  arp_wdata;
  logic         arp_we;
  logic [8:0]   txbuf_addr;
  logic [31:0]  txbuf_rdata;
  logic [31:0]  txbuf_wdata;
  logic         txbuf_we;
  logic [8:0]   rxbuf_addr;
  logic [31:0]  rxbuf_rdata;
  logic [11:0]  tx_size;
  logic         tx_ready;
  logic         tx_done;
  logic [11:0]  rx_size;
  logic         rx_ready;
  logic         rx_ack;
  logic [8:0]   mov_tx_addr;
  logic [31:0]  mov_tx_rdata;
  logic [8:0]   mov_rx_addr;
  logic [31:0]  mov_rx_wdata;
  logic         mov_rx_we;

  assign bus_req.cyc   = wb_cyc_i;
  assign bus_req.stb   = wb_stb_i;
  assign bus_req.we    = wb_we_i;
  assign bus_req.sel   = wb_sel_i;
  assign bus_req.addr  = wb_adr_i;
  assign bus_req.wdata = wb_dat_i;
  assign bus_req.pad   = 1'b0;
  assign wb_err_o      = 1'b0;

  gbe_cpu_regs u_regs (
    .cpu_clk, .cpu_rst, .bus_req_i(bus_req), .bus_rdata_o(wb_dat_o), .bus_ack_o(wb_ack_o),
    .phy_status_i, .phy_control_o, .local_cfg_o,
    .arp_addr_o(arp_addr), .arp_rdata_i(arp_rdata), .arp_wdata_o(arp_wdata), .arp_we_o(arp_we),
    .txbuf_addr_o(txbuf_addr), .txbuf_rdata_i(txbuf_rdata), .txbuf_wdata_o(txbuf_wdata),
    .txbuf_we_o(txbuf_we), .rxbuf_addr_o(rxbuf_addr), .rxbuf_rdata_i(rxbuf_rdata),
    .tx_size_o(tx_size), .tx_ready_o(tx_ready), .tx_done_i(tx_done),
    .rx_size_i(rx_size), .rx_ready_i(rx_ready), .rx_ack_o(rx_ack)
  );

  gbe_arp_cache u_arp (
    .cpu_clk, .addr_i(arp_addr), .wdata_i(arp_wdata), .we_i(arp_we), .rdata_o(arp_rdata)
  );

  gbe_packet_buffers u_buffers (
    .cpu_clk, .cpu_rst,
    .cpu_tx_addr_i(txbuf_addr), .cpu_tx_wdata_i(txbuf_wdata), .cpu_tx_we_i(txbuf_we),
    .cpu_tx_rdata_o(txbuf_rdata), .mov_tx_addr_i(mov_tx_addr), .mov_tx_rdata_o(mov_tx_rdata),
    .mov_rx_addr_i(mov_rx_addr), .mov_rx_wdata_i(mov_rx_wdata), .mov_rx_we_i(mov_rx_we),
    .cpu_rx_addr_i(rxbuf_addr), .cpu_rx_rdata_o(rxbuf_rdata), .rx_ack_i(rx_ack)
  );

  gbe_loopback_mover u_mover (
    .cpu_clk, .cpu_rst, .tx_ready_i(tx_ready), .tx_size_i(tx_size), .tx_done_o(tx_done),
    .tx_addr_o(mov_tx_addr), .tx_rdata_i(mov_tx_rdata), .rx_addr_o(mov_rx_addr),
    .rx_wdata_o(mov_rx_wdata), .rx_we_o(mov_rx_we), .rx_ready_o(rx_ready),
    .rx_size_o(rx_size), .rx_ack_i(rx_ack)
  );

endmodule

// File: logic/gbe_cpu_regs.sv
`timescale 1ns/1ps
module gbe_cpu_regs import gbe_cpu_pkg::*; (
  input  logic           cpu_clk,
  input  logic           cpu_rst,
  input  gbe_bus_req_t   bus_req_i,
  output logic [31:0]    bus_rdata_o,
  output logic           bus_ack_o,
  input  logic [31:0]    phy_status_i,
  output logic [31:0]    phy_control_o,
  output gbe_local_cfg_t local_cfg_o,
  output logic [7:0]     arp_addr_o,
  input  logic [47:0]    arp_rdata_i,
  output logic [47:0]    arp_wdata_o,
  output logic           arp_we_o,
  output logic [8:0]     txbuf_addr_o,
  input  logic [31:0]    txbuf_rdata_i,
  output logic [31:0]    txbuf_wdata_o,
  output logic           txbuf_we_o,
  output logic [8:0]     rxbuf_addr_o,
  input  logic [31:0]    rxbuf_rdata_i,
  output logic [11:0]    tx_size_o,
  output logic           tx_ready_o,
  input  logic           tx_done_i,
  input  logic [11:0]    rx_size_i,
  input  logic           rx_ready_i,
  output logic           rx_ack_o
);

  gbe_cpu_addr_u  addr;
  logic [31:0]    wdata;
  logic [3:0]     sel;
  logic           trans;
  logic           reg_sel;
  logic           tx_sel;
  logic           rx_sel;
  logic           arp_sel;
  logic           arp_half;
  logic [31:0]    mem_word;
  logic [31:0]    merged;
  logic [31:0]    reg_rdata;

  gbe_local_cfg_t cfg_q;
  logic [31:0]    phy_ctrl_q;
  logic [11:0]    tx_size_q;
  logic           tx_ready_q;
  logic [11:0]    rx_size_q;
  logic           rx_ack_q;
  logic           ack_q;
  logic           wait_q;
  logic           arp_we_q;
  logic           tx_we_q;
  logic           use_arp_q;
  logic           use_tx_q;
  logic           use_rx_q;
  logic [3:0]     data_src_q;
  logic [47:0]    wdata_q;

  function automatic logic [31:0] lane_merge(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  lanes);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign addr     = bus_req_i.addr;
  assign wdata    = bus_req_i.wdata;
  assign sel      = bus_req_i.sel;
  assign trans    = bus_req_i.cyc && bus_req_i.stb && !ack_q;
  assign reg_sel  = !addr.mem_view.hi && (addr.mem_view.region == REG_BASE[13:12]);
  assign tx_sel   = !addr.mem_view.hi && (addr.mem_view.region == TXBUF_BASE[13:12]);
  assign rx_sel   = !addr.mem_view.hi && (addr.mem_view.region == RXBUF_BASE[13:12]);
  assign arp_sel  = !addr.mem_view.hi && (addr.mem_view.region == ARP_BASE[13:12]);
  // word bit 0 picks low 32 bits of the entry
  assign arp_half = addr.mem_view.word[0];

  assign mem_word = tx_sel ? txbuf_rdata_i :
                    arp_half ? arp_rdata_i[31:0] : {16'h0, arp_rdata_i[47:32]};
  assign merged   = lane_merge(mem_word, wdata, sel);

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      cfg_q      <= '{RST_MAC, RST_IP, RST_PORT, RST_GATEWAY, RST_ENABLE, RST_PROMISC};
      phy_ctrl_q <= RST_PHY_CONTROL;
      tx_size_q  <= '0;
      tx_ready_q <= 1'b0;
      rx_size_q  <= '0;
      rx_ack_q   <= 1'b0;
      ack_q      <= 1'b0;
      wait_q     <= 1'b0;
      arp_we_q   <= 1'b0;
      tx_we_q    <= 1'b0;
      use_arp_q  <= 1'b0;
      use_tx_q   <= 1'b0;
      use_rx_q   <= 1'b0;
      data_src_q <= '0;
    end else begin
      ack_q     <= 1'b0;
      arp_we_q  <= 1'b0;
      tx_we_q   <= 1'b0;
      use_arp_q <= 1'b0;
      use_tx_q  <= 1'b0;
      use_rx_q  <= 1'b0;
      if (tx_done_i) begin
        tx_size_q  <= '0;
        tx_ready_q <= 1'b0;
      end
      // take a new packet only once the last one was released
      if (rx_ready_i && rx_size_q == 12'd0) begin
        rx_ack_q <= 1'b1;
      end
      if (rx_ready_i && rx_ack_q) begin
        rx_size_q <= rx_size_i;
        rx_ack_q  <= 1'b0;
      end
      if (wait_q) begin
        wait_q   <= 1'b0;
        ack_q    <= 1'b1;
        arp_we_q <= arp_sel;
        tx_we_q  <= tx_sel;
      end else if (trans) begin
        if ((arp_sel || tx_sel) && bus_req_i.we) begin
          wait_q <= 1'b1;
        end else begin
          ack_q <= 1'b1;
        end
        use_arp_q  <= arp_sel && !bus_req_i.we;
        use_tx_q   <= tx_sel && !bus_req_i.we;
        use_rx_q   <= rx_sel && !bus_req_i.we;
        data_src_q <= addr.reg_view.idx;
        if (reg_sel && bus_req_i.we) begin
          case (addr.reg_view.idx)
            REG_LOCAL_MAC_1: begin
              if (sel[0]) cfg_q.mac[39:32] <= wdata[7:0];
              if (sel[1]) cfg_q.mac[47:40] <= wdata[15:8];
            end
            REG_LOCAL_MAC_0: cfg_q.mac[31:0] <= lane_merge(cfg_q.mac[31:0], wdata, sel);
            REG_LOCAL_GATEWAY: if (sel[0]) cfg_q.gateway <= wdata[7:0];
            REG_LOCAL_IPADDR: cfg_q.ip <= lane_merge(cfg_q.ip, wdata, sel);
            REG_BUFFER_SIZES: begin
              // release of the received packet
              if (sel[0] && wdata[12:0] == 13'h0) rx_size_q <= '0;
              if (sel[2]) begin
                tx_size_q[7:0] <= wdata[23:16];
                tx_ready_q     <= 1'b1;
              end
              if (sel[3]) tx_size_q[11:8] <= wdata[27:24];
            end
            REG_VALID_PORTS: begin
              if (sel[0]) cfg_q.port[7:0]    <= wdata[7:0];
              if (sel[1]) cfg_q.port[15:8]   <= wdata[15:8];
              if (sel[2]) cfg_q.enable       <= wdata[16];
              if (sel[3]) cfg_q.promiscuous  <= wdata[24];
            end
            REG_PHY_CONTROL: phy_ctrl_q <= lane_merge(phy_ctrl_q, wdata, sel);
            default: ;
          endcase
        end
      end
    end
  end

  // merge in the wait cycle and write on the ack cycle
  always_ff @(posedge cpu_clk) begin
    if (wait_q) begin
      if (tx_sel) begin
        wdata_q <= {16'h0, merged};
      end else if (arp_half) begin
        wdata_q <= {arp_rdata_i[47:32], merged};
      end else begin
        wdata_q <= {merged[15:0], arp_rdata_i[31:0]};
      end
    end
  end

  always_comb begin
    case (data_src_q)
      REG_LOCAL_MAC_1:   reg_rdata = {16'h0, cfg_q.mac[47:32]};
      REG_LOCAL_MAC_0:   reg_rdata = cfg_q.mac[31:0];
      REG_LOCAL_GATEWAY: reg_rdata = {24'h0, cfg_q.gateway};
      REG_LOCAL_IPADDR:  reg_rdata = cfg_q.ip;
      REG_BUFFER_SIZES:  reg_rdata = {4'h0, tx_size_q, 4'h0, rx_size_q};
      REG_VALID_PORTS:   reg_rdata = {7'h0, cfg_q.promiscuous, 7'h0, cfg_q.enable, cfg_q.port};
      REG_PHY_STATUS:    reg_rdata = phy_status_i;
      REG_PHY_CONTROL:   reg_rdata = phy_ctrl_q;
      default:           reg_rdata = 32'h0;
    endcase
  end

  assign bus_rdata_o   = use_arp_q ? mem_word :
                         use_tx_q  ? txbuf_rdata_i :
                         use_rx_q  ? rxbuf_rdata_i : reg_rdata;
  assign bus_ack_o     = ack_q;
  assign phy_control_o = phy_ctrl_q;
  assign local_cfg_o   = cfg_q;
  assign arp_addr_o    = addr.mem_view.word[8:1];
  assign arp_wdata_o   = wdata_q;
  assign arp_we_o      = arp_we_q;
  assign txbuf_addr_o  = addr.mem_view.word;
  assign txbuf_wdata_o = wdata_q[31:0];
  assign txbuf_we_o    = tx_we_q;
  assign rxbuf_addr_o  = addr.mem_view.word;
  assign tx_size_o     = tx_size_q;
  assign tx_ready_o    = tx_ready_q;
  assign rx_ack_o      = rx_ack_q;

endmodule

// File: logic/gbe_loopback_mover.sv
`timescale 1ns/1ps
module gbe_loopback_mover (
  input  logic        cpu_clk,
  input  logic        cpu_rst,
  input  logic        tx_ready_i,
  input  logic [11:0] tx_size_i,
  output logic        tx_done_o,
  output logic [8:0]  tx_addr_o,
  input  logic [31:0] tx_rdata_i,
  output logic [8:0]  rx_addr_o,
  output logic [31:0] rx_wdata_o,
  output logic        rx_we_o,
  output logic        rx_ready_o,
  output logic [11:0] rx_size_o,
  input  logic        rx_ack_i
);

  typedef enum logic [1:0] {IDLE, COPY, PRESENT} mover_state_e;

  mover_state_e state_q;
  logic [11:0]  size_q;
  logic [11:0]  rd_cnt_q;
  logic [8:0]   wr_addr_q;
  logic         rx_we_q;
  logic         done_q;
  logic         ready_q;

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      state_q  <= IDLE;
      rd_cnt_q <= '0;
      rx_we_q  <= 1'b0;
      done_q   <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      rx_we_q <= 1'b0;
      done_q  <= 1'b0;
      case (state_q)
        IDLE: begin
          rd_cnt_q <= '0;
          if (tx_ready_i && !done_q) begin
            // empty packet, nothing to present
            if (tx_size_i == 12'd0) done_q  <= 1'b1;
            else                    state_q <= COPY;
          end
        end
        COPY: begin
          rd_cnt_q <= rd_cnt_q + 12'd1;
          rx_we_q  <= 1'b1;
          if (rd_cnt_q == size_q - 12'd1) begin
            state_q <= PRESENT;
            done_q  <= 1'b1;
            ready_q <= 1'b1;
          end
        end
        PRESENT: begin
          if (rx_ack_i) begin
            ready_q <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // write trails the read by one cycle of memory latency
  always_ff @(posedge cpu_clk) begin
    if (state_q == IDLE) size_q <= tx_size_i;
    wr_addr_q <= rd_cnt_q[8:0];
  end

  assign tx_addr_o  = rd_cnt_q[8:0];
  assign rx_addr_o  = wr_addr_q;
  assign rx_wdata_o = tx_rdata_i;
  assign rx_we_o    = rx_we_q;
  assign tx_done_o  = done_q;
  assign rx_ready_o = ready_q;
  assign rx_size_o  = size_q;

endmodule

// File: logic/gbe_packet_buffers.sv
`timescale 1ns/1ps
module gbe_packet_buffers import gbe_cpu_pkg::*; (
  input  logic        cpu_clk,
  input  logic        cpu_rst,
  input  logic [8:0]  cpu_tx_addr_i,
  input  logic [31:0] cpu_tx_wdata_i,
  input  logic        cpu_tx_we_i,
  output logic [31:0] cpu_tx_rdata_o,
  input  logic [8:0]  mov_tx_addr_i,
  output logic [31:0] mov_tx_rdata_o,
  input  logic [8:0]  mov_rx_addr_i,
  input  logic [31:0] mov_rx_wdata_i,
  input  logic        mov_rx_we_i,
  input  logic [8:0]  cpu_rx_addr_i,
  output logic [31:0] cpu_rx_rdata_o,
  input  logic        rx_ack_i
);

  logic [31:0] tx_mem [TXBUF_WORDS];
  logic [31:0] rx_mem [2*TXBUF_WORDS];
  logic        bank_q;

  always_ff @(posedge cpu_clk) begin
    if (cpu_tx_we_i) begin
      tx_mem[cpu_tx_addr_i] <= cpu_tx_wdata_i;
    end
    cpu_tx_rdata_o <= tx_mem[cpu_tx_addr_i];
    mov_tx_rdata_o <= tx_mem[mov_tx_addr_i];
  end

  // mover fills the bank the cpu is not reading
  always_ff @(posedge cpu_clk) begin
    if (mov_rx_we_i) begin
      rx_mem[{~bank_q, mov_rx_addr_i}] <= mov_rx_wdata_i;
    end
    cpu_rx_rdata_o <= rx_mem[{bank_q, cpu_rx_addr_i}];
  end

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      bank_q <= 1'b0;
    end else if (rx_ack_i) begin
      bank_q <= ~bank_q;
    end
  end

endmodule

// File: logic/gbe_arp_cache.sv
`timescale 1ns/1ps
module gbe_arp_cache import gbe_cpu_pkg::*; (
  input  logic        cpu_clk,
  input  logic [7:0]  addr_i,
  input  logic [47:0] wdata_i,
  input  logic        we_i,
  output logic [47:0] rdata_o
);

  logic [47:0] mem [ARP_ENTRIES];

  always_ff @(posedge cpu_clk) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // combinational read for the merge in the wait cycle
  assign rdata_o = mem[addr_i];

endmodule

// File: logic/gbe_cpu_pkg.sv
package gbe_cpu_pkg;

  // region start addresses, 0x800 bytes each
  localparam logic [13:0] REG_BASE   = 14'h0000;
  localparam logic [13:0] TXBUF_BASE = 14'h1000;
  localparam logic [13:0] RXBUF_BASE = 14'h2000;
  localparam logic [13:0] ARP_BASE   = 14'h3000;

  localparam logic [3:0] REG_LOCAL_MAC_1   = 4'd0;
  localparam logic [3:0] REG_LOCAL_MAC_0   = 4'd1;
  localparam logic [3:0] REG_LOCAL_GATEWAY = 4'd3;
  localparam logic [3:0] REG_LOCAL_IPADDR  = 4'd4;
  localparam logic [3:0] REG_BUFFER_SIZES  = 4'd6;
  localparam logic [3:0] REG_VALID_PORTS   = 4'd8;
  localparam logic [3:0] REG_PHY_STATUS    = 4'd9;
  localparam logic [3:0] REG_PHY_CONTROL   = 4'd10;

  localparam logic [47:0] RST_MAC         = 48'h0200_0000_0001;
  localparam logic [31:0] RST_IP          = 32'hc0a8_0101;
  localparam logic [15:0] RST_PORT        = 16'h2710;
  localparam logic [7:0]  RST_GATEWAY     = 8'h01;
  localparam logic        RST_ENABLE      = 1'b0;
  localparam logic        RST_PROMISC     = 1'b0;
  localparam logic [31:0] RST_PHY_CONTROL = 32'h0000_0000;

  localparam int TXBUF_WORDS = 512;
  localparam int ARP_ENTRIES = 256;

  typedef struct packed {
    logic [1:0] region;
    logic [5:0] unused;
    logic [3:0] idx;
    logic [1:0] offset;
  } gbe_reg_view_t;

  typedef struct packed {
    logic [1:0] region;
    logic       hi;
    logic [8:0] word;
    logic [1:0] offset;
  } gbe_mem_view_t;

  typedef union packed {
    gbe_reg_view_t reg_view;
    gbe_mem_view_t mem_view;
  } gbe_cpu_addr_u;

  typedef struct packed {
    logic          cyc;
    logic          stb;
    logic          we;
    logic [3:0]    sel;
    gbe_cpu_addr_u addr;
    logic [31:0]   wdata;
    logic          pad;
  } gbe_bus_req_t;

  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
    logic [7:0]  gateway;
    logic        enable;
    logic        promiscuous;
  } gbe_local_cfg_t;

endpackage
